/* Bender.yml */
package:
  name: f8_dot

sources:
  - files:
      - design/tcu_fmt_pkg.sv
      - design/tcu_cfg_pkg.sv
      - design/f8_classifier.sv
      - design/f8_pair_mul.sv
      - design/lane_reduce.sv
      - design/fp32_normalize.sv
      - design/dot_control.sv
      - design/f8_dot_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_f8_dot_top.sv

/* design/dot_control.sv */
`timescale 1ns/1ps

module dot_control (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   valid_in,
    input  logic [tcu_cfg_pkg::TAG_W-1:0]          req_id,
    input  logic [2:0]                             fmt_f,
    output logic [tcu_cfg_pkg::PIPE_DEPTH-1:0]     stage_en,
    output logic                                   fmt_err_s2,
    output logic                                   valid_out,
    output logic [tcu_cfg_pkg::TAG_W-1:0]          req_id_out,
    output logic                                   fmt_err
);
    import tcu_cfg_pkg::*;
    import tcu_fmt_pkg::*;

    logic [PIPE_DEPTH-1:0]            vld_q;
    logic [PIPE_DEPTH-1:0]            err_q;
    logic [PIPE_DEPTH-1:0][TAG_W-1:0] tag_q;

    // Format checked once at entry
    wire fmt_bad = (fmt_f != fmt_fp8_id) && (fmt_f != fmt_bf8_id);

    // Valid and error chains
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
            err_q <= '0;
        end else begin
            vld_q <= {vld_q[PIPE_DEPTH-2:0], valid_in};
            err_q <= {err_q[PIPE_DEPTH-2:0], valid_in & fmt_bad};
        end
    end

    // Tag rides beside the data
    always_ff @(posedge clk) begin
        tag_q <= {tag_q[PIPE_DEPTH-2:0], req_id};
    end

    // Bit n loads the stage n+1 registers
    assign stage_en   = {vld_q[PIPE_DEPTH-2:0], valid_in};
    assign fmt_err_s2 = err_q[1];
    assign valid_out  = vld_q[PIPE_DEPTH-1];
    assign fmt_err    = err_q[PIPE_DEPTH-1];
    assign req_id_out = tag_q[PIPE_DEPTH-1];

    a_valid_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(valid_out))
        else $error("valid_out unknown");

    a_err_with_valid: assert property (@(posedge clk) disable iff (rst)
        fmt_err |-> valid_out)
        else $error("fmt_err without valid_out");

endmodule

/* design/f8_classifier.sv */
`timescale 1ns/1ps

module f8_classifier (
    input  logic [2:0]                                 fmt_f,
    input  logic [tcu_cfg_pkg::NUM_WORDS-1:0][31:0]    elems,
    output tcu_fmt_pkg::elem_class_t [tcu_cfg_pkg::NUM_ELEMS-1:0] cls
);
    import tcu_cfg_pkg::*;
    import tcu_fmt_pkg::*;

    // Field layout of the selected format
    wire       is_bf    = fmt_is_bfloat(fmt_f);
    wire [2:0] man_w    = 3'(man_bits(fmt_f));
    wire [4:0] exp_ones = 5'((1 << exp_bits(fmt_f)) - 1);
    wire [2:0] man_ones = 3'((1 << man_bits(fmt_f)) - 1);

    for (genvar e = 0; e < NUM_ELEMS; e++) begin : g_elem
        wire [7:0] raw   = elems[e / ELEMS_PER_WORD][8 * (e % ELEMS_PER_WORD) +: 8];
        wire [2:0] man_f = raw[2:0] & man_ones;
        wire [4:0] exp_f = 5'(raw[6:0] >> man_w);
        wire       e_max = (exp_f == exp_ones);

        // fp8 has no Inf, only S.1111.111 is NaN
        wire nan = e_max && (is_bf ? (man_f != 3'd0) : (man_f == man_ones));
        // bf8 follows IEEE
        wire inf = e_max && is_bf && (man_f == 3'd0);

        assign cls[e] = '{
            sign:    raw[7],
            is_zero: (exp_f == 5'd0) && (man_f == 3'd0),
            is_sub:  (exp_f == 5'd0) && (man_f != 3'd0),
            is_inf:  inf,
            is_nan:  nan
        };
    end

endmodule

/* design/f8_dot_top.sv */
`timescale 1ns/1ps

module f8_dot_top (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      valid_in,
    input  logic [tcu_cfg_pkg::TAG_W-1:0]             req_id,
    input  logic [2:0]                                fmt_f,
    input  logic [tcu_cfg_pkg::NUM_ELEMS-1:0]         vld_mask,
    input  logic [tcu_cfg_pkg::NUM_WORDS-1:0][31:0]   a_row,
    input  logic [tcu_cfg_pkg::NUM_WORDS-1:0][31:0]   b_col,
    output logic                                      valid_out,
    output logic [tcu_cfg_pkg::TAG_W-1:0]             req_id_out,
    output logic [31:0]                               result,
    output logic                                      result_nan,
    output logic                                      result_inf,
    output logic                                      fmt_err
);
    import tcu_cfg_pkg::*;
    import tcu_fmt_pkg::*;

    logic [PIPE_DEPTH-1:0] stage_en;
    logic                  fmt_err_s2;

    // Lane buses into stage 1
    logic [NUM_LANES-1:0][LANE_SIG_W-1:0] lane_sig;
    logic [NUM_LANES-1:0]                 lane_sign;
    logic [NUM_LANES-1:0][LANE_EXP_W-1:0] lane_exp;
    dot_excep_t [NUM_LANES-1:0]           lane_excep;

    // Reduced sum into stage 3
    logic [RED_W-1:0]      red_sum;
    logic                  red_sign;
    logic [LANE_EXP_W-1:0] red_exp;
    dot_excep_t            red_excep;

    dot_control u_ctrl (
        .clk(clk), .rst(rst), .valid_in(valid_in), .req_id(req_id), .fmt_f(fmt_f),
        .stage_en(stage_en), .fmt_err_s2(fmt_err_s2), .valid_out(valid_out),
        .req_id_out(req_id_out), .fmt_err(fmt_err)
    );

    f8_pair_mul u_mul (
        .fmt_f(fmt_f), .vld_mask(vld_mask), .a_row(a_row), .b_col(b_col),
        .lane_sig(lane_sig), .lane_sign(lane_sign), .lane_exp(lane_exp),
        .lane_excep(lane_excep)
    );

    lane_reduce u_reduce (
        .clk(clk), .rst(rst), .stage_en(stage_en[1:0]),
        .lane_sig(lane_sig), .lane_sign(lane_sign), .lane_exp(lane_exp),
        .lane_excep(lane_excep), .red_sum(red_sum), .red_sign(red_sign),
        .red_exp(red_exp), .red_excep(red_excep)
    );

    fp32_normalize u_norm (
        .clk(clk), .rst(rst), .stage_en(stage_en[2]),
        .red_sum(red_sum), .red_sign(red_sign), .red_exp(red_exp),
        .red_excep(red_excep), .fmt_err_s2(fmt_err_s2),
        .result(result), .result_nan(result_nan), .result_inf(result_inf)
    );

endmodule

/* design/f8_pair_mul.sv */
`timescale 1ns/1ps

module f8_pair_mul (
    input  logic [2:0]                                              fmt_f,
    input  logic [tcu_cfg_pkg::NUM_ELEMS-1:0]                       vld_mask,
    input  logic [tcu_cfg_pkg::NUM_WORDS-1:0][31:0]                 a_row,
    input  logic [tcu_cfg_pkg::NUM_WORDS-1:0][31:0]                 b_col,
    output logic [tcu_cfg_pkg::NUM_LANES-1:0][tcu_cfg_pkg::LANE_SIG_W-1:0] lane_sig,
    output logic [tcu_cfg_pkg::NUM_LANES-1:0]                       lane_sign,
    output logic [tcu_cfg_pkg::NUM_LANES-1:0][tcu_cfg_pkg::LANE_EXP_W-1:0] lane_exp,
    output tcu_fmt_pkg::dot_excep_t [tcu_cfg_pkg::NUM_LANES-1:0]    lane_excep
);
    import tcu_cfg_pkg::*;
    import tcu_fmt_pkg::*;

    // Hidden bit and mantissa with bf8 padded to the fp8 binary point
    function automatic logic [3:0] mant_of(input logic [7:0] raw, input logic sub,
                                           input logic bf);
        return bf ? {~sub, raw[1:0], 1'b0} : {~sub, raw[2:0]};
    endfunction

    // Subnormals use exponent 1
    function automatic logic [4:0] exp_of(input logic [7:0] raw, input logic sub,
                                          input logic bf);
        if (sub) begin
            return 5'd1;
        end
        return bf ? raw[6:2] : {1'b0, raw[6:3]};
    endfunction

    elem_class_t [NUM_ELEMS-1:0] cls_a;
    elem_class_t [NUM_ELEMS-1:0] cls_b;

    logic [NUM_ELEMS-1:0][7:0]            prod;
    logic [NUM_ELEMS-1:0][LANE_EXP_W-1:0] pexp;
    logic [NUM_ELEMS-1:0]                 live;
    logic [NUM_ELEMS-1:0]                 psign;
    logic [NUM_ELEMS-1:0]                 pnan;
    logic [NUM_ELEMS-1:0]                 pinf;

    wire is_bf = fmt_is_bfloat(fmt_f);
    // Removes both format biases and adds the lane offset
    wire [LANE_EXP_W-1:0] exp_off = LANE_EXP_W'(LANE_EXP_OFF - 2 * fmt_bias(fmt_f));

    f8_classifier u_cls_a (.fmt_f(fmt_f), .elems(a_row), .cls(cls_a));
    f8_classifier u_cls_b (.fmt_f(fmt_f), .elems(b_col), .cls(cls_b));

    // ------------------------------------------------------------
    // Per-pair products
    // ------------------------------------------------------------
    for (genvar e = 0; e < NUM_ELEMS; e++) begin : g_pair
        wire [7:0] ra = a_row[e / ELEMS_PER_WORD][8 * (e % ELEMS_PER_WORD) +: 8];
        wire [7:0] rb = b_col[e / ELEMS_PER_WORD][8 * (e % ELEMS_PER_WORD) +: 8];
        wire inf_zero = (cls_a[e].is_inf & cls_b[e].is_zero) |
                        (cls_a[e].is_zero & cls_b[e].is_inf);

        // Masked or zero pairs add nothing
        assign live[e] = vld_mask[e] & ~cls_a[e].is_zero & ~cls_b[e].is_zero;
        assign prod[e] = live[e] ? mant_of(ra, cls_a[e].is_sub, is_bf) *
                                   mant_of(rb, cls_b[e].is_sub, is_bf) : 8'd0;
        assign pexp[e] = LANE_EXP_W'(exp_of(ra, cls_a[e].is_sub, is_bf)) +
                         LANE_EXP_W'(exp_of(rb, cls_b[e].is_sub, is_bf)) + exp_off;
        assign psign[e] = cls_a[e].sign ^ cls_b[e].sign;
        assign pnan[e]  = vld_mask[e] & (cls_a[e].is_nan | cls_b[e].is_nan | inf_zero);
        assign pinf[e]  = vld_mask[e] & (cls_a[e].is_inf | cls_b[e].is_inf) & ~pnan[e];
    end

    // ------------------------------------------------------------
    // Two products merged per lane
    // ------------------------------------------------------------
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        wire first_max = live[2*i] & (~live[2*i+1] | (pexp[2*i] >= pexp[2*i+1]));

        wire [LANE_EXP_W-1:0] e_big = first_max ? pexp[2*i] : pexp[2*i+1];
        wire [LANE_EXP_W-1:0] e_sml = first_max ? pexp[2*i+1] : pexp[2*i];
        wire [LANE_EXP_W-1:0] diff  = e_big - e_sml;
        wire [7:0] p_big = first_max ? prod[2*i] : prod[2*i+1];
        wire [7:0] p_sml = first_max ? prod[2*i+1] : prod[2*i];
        wire       s_big = first_max ? psign[2*i] : psign[2*i+1];
        wire       s_sml = first_max ? psign[2*i+1] : psign[2*i];

        // One bit of headroom for the carry of the sum
        wire [LANE_SIG_W-1:0] m_big = {1'b0, p_big, 15'd0};
        wire [LANE_SIG_W-1:0] m_sml = (diff >= LANE_SIG_W) ? '0 : {1'b0, p_sml, 15'd0} >> diff;

        // Signed add where exact cancellation lands on +0
        wire [LANE_SIG_W:0] t_big = s_big ? -{1'b0, m_big} : {1'b0, m_big};
        wire [LANE_SIG_W:0] t_sml = s_sml ? -{1'b0, m_sml} : {1'b0, m_sml};
        wire [LANE_SIG_W:0] acc   = t_big + t_sml;

        // Inf of both signs in one lane is NaN
        wire pos_inf = |(pinf[2*i +: 2] & ~psign[2*i +: 2]);
        wire neg_inf = |(pinf[2*i +: 2] & psign[2*i +: 2]);
        wire nan_l   = |pnan[2*i +: 2] | (pos_inf & neg_inf);
        wire inf_l   = (pos_inf | neg_inf) & ~nan_l;

        assign lane_sign[i]  = acc[LANE_SIG_W];
        assign lane_sig[i]   = acc[LANE_SIG_W] ? LANE_SIG_W'(-acc) : acc[LANE_SIG_W-1:0];
        assign lane_exp[i]   = e_big;
        assign lane_excep[i] = '{is_nan: nan_l, is_inf: inf_l,
                                 sign: inf_l ? neg_inf : acc[LANE_SIG_W]};
    end

    // Elements feeding a lane decode as NaN or as Inf but never as both
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            for (int j = 0; j < 2; j++) begin
                assert final (!(cls_a[2*i+j].is_nan && cls_a[2*i+j].is_inf) &&
                              !(cls_b[2*i+j].is_nan && cls_b[2*i+j].is_inf))
                    else $error("lane %0d has an element flagged NaN and Inf together", i);
            end
        end
    end

endmodule

/* design/fp32_normalize.sv */
`timescale 1ns/1ps

module fp32_normalize (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   stage_en,
    input  logic [tcu_cfg_pkg::RED_W-1:0]          red_sum,
    input  logic                                   red_sign,
    input  logic [tcu_cfg_pkg::LANE_EXP_W-1:0]     red_exp,
    input  tcu_fmt_pkg::dot_excep_t                red_excep,
    input  logic                                   fmt_err_s2,
    output logic [31:0]                            result,
    output logic                                   result_nan,
    output logic                                   result_inf
);
    import tcu_cfg_pkg::*;
    import tcu_fmt_pkg::*;

    logic [4:0]  lz;
    logic [31:0] nxt_result;
    logic        nxt_nan;
    logic        nxt_inf;

    // Leading zero count, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < RED_W; i++) begin
            if (red_sum[i]) begin
                lz = 5'(RED_W - 1 - i);
            end
        end
    end

    // 24-bit significand with guard and sticky
    wire [RED_W-1:0] norm   = red_sum << lz;
    wire [23:0]      sig24  = norm[RED_W-1 -: 24];
    wire             guard  = norm[RED_W-25];
    wire             sticky = |norm[RED_W-26:0];

    // Nearest-even
    wire        rnd_up  = guard & (sticky | sig24[0]);
    wire [24:0] sig_rnd = {1'b0, sig24} + 25'(rnd_up);
    wire        carry   = sig_rnd[24];
    wire [22:0] frac    = carry ? sig_rnd[23:1] : sig_rnd[22:0];

    // Lane exponent back to the fp32 bias
    wire signed [11:0] exp_c = 12'(red_exp) - 12'(lz) + 12'(carry) +
                               12'(RED_W - 1 + F32_BIAS - LANE_EXP_OFF - LANE_FRAC);

    // ------------------------------------------------------------
    // Result packing
    // ------------------------------------------------------------
    always_comb begin
        nxt_nan    = 1'b0;
        nxt_inf    = 1'b0;
        nxt_result = {red_sign, exp_c[7:0], frac};
        if (fmt_err_s2 || red_excep.is_nan) begin
            nxt_nan    = 1'b1;
            nxt_result = f32_qnan;
        end else if (red_excep.is_inf) begin
            nxt_inf    = 1'b1;
            nxt_result = {red_excep.sign, 8'hFF, 23'd0};
        end else if (red_sum == '0) begin
            nxt_result = 32'd0;
        end else if (exp_c >= 12'sd255) begin
            // Overflow saturates to Inf
            nxt_inf    = 1'b1;
            nxt_result = {red_sign, 8'hFF, 23'd0};
        end else if (exp_c <= 12'sd0) begin
            nxt_result = {red_sign, 31'd0};
        end
    end

    // Stage 3 output registers
    always_ff @(posedge clk) begin
        if (stage_en) begin
            result <= nxt_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_nan <= 1'b0;
            result_inf <= 1'b0;
        end else if (stage_en) begin
            result_nan <= nxt_nan;
            result_inf <= nxt_inf;
        end
    end

    a_nan_inf_excl: assert property (@(posedge clk) disable iff (rst)
        !(result_nan && result_inf))
        else $error("result flags NaN and Inf together");

endmodule

/* design/lane_reduce.sv */
`timescale 1ns/1ps

module lane_reduce (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic [1:0]                                              stage_en,
    input  logic [tcu_cfg_pkg::NUM_LANES-1:0][tcu_cfg_pkg::LANE_SIG_W-1:0] lane_sig,
    input  logic [tcu_cfg_pkg::NUM_LANES-1:0]                       lane_sign,
    input  logic [tcu_cfg_pkg::NUM_LANES-1:0][tcu_cfg_pkg::LANE_EXP_W-1:0] lane_exp,
    input  tcu_fmt_pkg::dot_excep_t [tcu_cfg_pkg::NUM_LANES-1:0]    lane_excep,
    output logic [tcu_cfg_pkg::RED_W-1:0]                           red_sum,
    output logic                                                    red_sign,
    output logic [tcu_cfg_pkg::LANE_EXP_W-1:0]                      red_exp,
    output tcu_fmt_pkg::dot_excep_t                                 red_excep
);
    import tcu_cfg_pkg::*;
    import tcu_fmt_pkg::*;

    logic [NUM_LANES-1:0][LANE_SIG_W-1:0] s1_sig;
    logic [NUM_LANES-1:0]                 s1_sign;
    logic [NUM_LANES-1:0][LANE_EXP_W-1:0] s1_exp;
    dot_excep_t [NUM_LANES-1:0]           s1_excep;

    logic [LANE_EXP_W-1:0] max_exp;
    logic [RED_W-1:0]      acc;
    dot_excep_t            nxt_excep;

    // ------------------------------------------------------------
    // Stage 1 lane registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (stage_en[0]) begin
            s1_sig  <= lane_sig;
            s1_sign <= lane_sign;
            s1_exp  <= lane_exp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_excep <= '0;
        end else if (stage_en[0]) begin
            s1_excep <= lane_excep;
        end
    end

    // Largest exponent, empty lanes ignored
    always_comb begin
        max_exp = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (s1_sig[i] != '0 && s1_exp[i] > max_exp) begin
                max_exp = s1_exp[i];
            end
        end
    end

    // Align to max_exp and sum as two's complement
    always_comb begin
        logic [LANE_EXP_W-1:0] shamt;
        logic [RED_W-1:0]      aligned;
        acc = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            shamt   = max_exp - s1_exp[i];
            aligned = (shamt >= RED_W) ? '0 : RED_W'(s1_sig[i]) >> shamt;
            acc     = acc + (s1_sign[i] ? -aligned : aligned);
        end
    end

    // Same NaN and Inf rules as within a lane
    always_comb begin
        logic any_nan;
        logic pos_inf;
        logic neg_inf;
        any_nan = 1'b0;
        pos_inf = 1'b0;
        neg_inf = 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            any_nan = any_nan | s1_excep[i].is_nan;
            pos_inf = pos_inf | (s1_excep[i].is_inf & ~s1_excep[i].sign);
            neg_inf = neg_inf | (s1_excep[i].is_inf & s1_excep[i].sign);
        end
        nxt_excep.is_nan = any_nan | (pos_inf & neg_inf);
        nxt_excep.is_inf = (pos_inf | neg_inf) & ~nxt_excep.is_nan;
        nxt_excep.sign   = neg_inf;
    end

    // ------------------------------------------------------------
    // Stage 2 sum registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (stage_en[1]) begin
            red_sum  <= acc[RED_W-1] ? -acc : acc;
            red_sign <= acc[RED_W-1];
            red_exp  <= max_exp;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            red_excep <= '0;
        end else if (stage_en[1]) begin
            red_excep <= nxt_excep;
        end
    end

endmodule

/* design/tcu_cfg_pkg.sv */
package tcu_cfg_pkg;

    // Request shape
    localparam int NUM_WORDS      = 2;
    localparam int ELEMS_PER_WORD = 4;
    localparam int NUM_ELEMS      = NUM_WORDS * ELEMS_PER_WORD;
    localparam int NUM_LANES      = NUM_ELEMS / 2;

    // Lane magnitude and exponent, sign travels separately
    localparam int LANE_SIG_W   = 24;
    localparam int LANE_EXP_W   = 10;
    // Lane exponent offset keeps every exponent sum positive
    localparam int LANE_EXP_OFF = 128;
    // Binary point of a lane: 6 from the product, 15 of padding
    localparam int LANE_FRAC    = 21;

    localparam int RED_W      = 28;
    localparam int F32_BIAS   = 127;
    localparam int TAG_W      = 32;
    localparam int PIPE_DEPTH = 3;

endpackage

/* design/tcu_fmt_pkg.sv */
package tcu_fmt_pkg;

    // Format codes, every other code is illegal
    localparam logic [2:0] fmt_fp8_id = 3'd0;
    localparam logic [2:0] fmt_bf8_id = 3'd1;

    // Canonical fp32 quiet NaN
    localparam logic [31:0] f32_qnan = 32'h7FC0_0000;

    // Per-element decode
    typedef struct packed {
        logic sign;
        logic is_zero;
        logic is_sub;
        logic is_inf;
        logic is_nan;
    } elem_class_t;

    // Exception state carried beside a partial sum
    typedef struct packed {
        logic is_nan;
        logic is_inf;
        logic sign;
    } dot_excep_t;

    function automatic logic fmt_is_bfloat(input logic [2:0] fmt);
        return fmt == fmt_bf8_id;
    endfunction

    // E4M3 for fp8, E5M2 for bf8
    function automatic int unsigned exp_bits(input logic [2:0] fmt);
        return fmt_is_bfloat(fmt) ? 5 : 4;
    endfunction

    function automatic int unsigned man_bits(input logic [2:0] fmt);
        return fmt_is_bfloat(fmt) ? 2 : 3;
    endfunction

    function automatic int unsigned fmt_bias(input logic [2:0] fmt);
        return fmt_is_bfloat(fmt) ? 15 : 7;
    endfunction

endpackage

/* sim.f */
+incdir+sim
design/tcu_fmt_pkg.sv
design/tcu_cfg_pkg.sv
design/f8_classifier.sv
design/f8_pair_mul.sv
design/lane_reduce.sv
design/fp32_normalize.sv
design/dot_control.sv
design/f8_dot_top.sv
sim/tb_f8_dot_top.sv

/* sim/tb_f8_model.svh */
`ifndef TB_F8_MODEL_SVH
`define TB_F8_MODEL_SVH

// Expected response of one request
typedef struct packed {
    logic [31:0] tag;
    logic        fmt_err;
    logic        nan;
    logic        inf;
    logic [31:0] result;
} exp_t;

logic [31:0] rng_state;

// xorshift32 step
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Exponent field kept narrow so product exponents stay within 12
function automatic logic [7:0] rand_elem(input logic bf);
    logic [31:0] r;
    r = next_rand();
    if (bf) begin
        // Field 0 gives zeros and subnormals
        return {r[0], 5'(r[7:4] % 7), r[2:1]};
    end
    return {r[0], 4'(4 + r[7:4] % 7), r[3:1]};
endfunction

function automatic logic [63:0] rand_vec(input logic bf);
    logic [63:0] v;
    for (int e = 0; e < 8; e++) begin
        v[8*e +: 8] = rand_elem(bf);
    end
    return v;
endfunction

function automatic real pow2(input int n);
    real r;
    r = 1.0;
    for (int i = 0; i < n; i++) begin
        r = r * 2.0;
    end
    for (int i = 0; i > n; i--) begin
        r = r / 2.0;
    end
    return r;
endfunction

// Element value, Inf and NaN return a dummy 1.0
function automatic real decode(input logic [7:0] v, input logic bf,
                               output logic nan, output logic inf);
    int  ex;
    int  mn;
    real mag;
    ex  = bf ? int'(v[6:2]) : int'(v[6:3]);
    mn  = bf ? int'(v[1:0]) : int'(v[2:0]);
    // E4M3 keeps only S.1111.111 for NaN
    nan = bf ? (ex == 31 && mn != 0) : (ex == 15 && mn == 7);
    inf = bf && ex == 31 && mn == 0;
    if (nan || inf) begin
        return 1.0;
    end
    if (bf) begin
        mag = (ex == 0) ? mn / 4.0 * pow2(-14) : (1.0 + mn / 4.0) * pow2(ex - 15);
    end else begin
        mag = (ex == 0) ? mn / 8.0 * pow2(-6) : (1.0 + mn / 8.0) * pow2(ex - 7);
    end
    return v[7] ? -mag : mag;
endfunction

// Round an exact real to fp32, nearest-even, normal range only
function automatic logic [31:0] to_fp32(input real x);
    logic    s;
    int      e;
    real     m;
    real     fl;
    longint  q;
    if (x == 0.0) begin
        return 32'd0;
    end
    s = (x < 0.0);
    m = s ? -x : x;
    e = 0;
    while (m >= 2.0) begin
        m = m / 2.0;
        e++;
    end
    while (m < 1.0) begin
        m = m * 2.0;
        e--;
    end
    // 23 fraction bits above the point, the rest decides rounding
    m  = m * 8388608.0;
    fl = $floor(m);
    q  = longint'(fl);
    if ((m - fl) > 0.5 || ((m - fl) == 0.5 && q[0])) begin
        q = q + 1;
    end
    if (q == 64'd16777216) begin
        q = q >> 1;
        e++;
    end
    return {s, 8'(e + 127), q[22:0]};
endfunction

// Exact sum of the masked products, then one rounding
function automatic exp_t model_dot(input logic [2:0] fmt, input logic [7:0] mask,
                                   input logic [63:0] a, input logic [63:0] b,
                                   input logic [31:0] tag);
    exp_t r;
    logic bf;
    logic na;
    logic ia;
    logic nb;
    logic ib;
    logic any_nan;
    logic pos_inf;
    logic neg_inf;
    real  va;
    real  vb;
    real  sum;
    r       = '0;
    r.tag   = tag;
    any_nan = 1'b0;
    pos_inf = 1'b0;
    neg_inf = 1'b0;
    sum     = 0.0;
    if (fmt != 3'd0 && fmt != 3'd1) begin
        r.fmt_err = 1'b1;
        r.nan     = 1'b1;
        r.result  = 32'h7FC0_0000;
        return r;
    end
    bf = (fmt == 3'd1);
    for (int e = 0; e < 8; e++) begin
        if (mask[e]) begin
            va = decode(a[8*e +: 8], bf, na, ia);
            vb = decode(b[8*e +: 8], bf, nb, ib);
            if (na || nb || (ia && vb == 0.0) || (ib && va == 0.0)) begin
                any_nan = 1'b1;
            end else if (ia || ib) begin
                // Sign of an infinite product
                if (a[8*e+7] ^ b[8*e+7]) begin
                    neg_inf = 1'b1;
                end else begin
                    pos_inf = 1'b1;
                end
            end else begin
                sum = sum + va * vb;
            end
        end
    end
    if (any_nan || (pos_inf && neg_inf)) begin
        r.nan    = 1'b1;
        r.result = 32'h7FC0_0000;
    end else if (pos_inf || neg_inf) begin
        r.inf    = 1'b1;
        r.result = {neg_inf, 8'hFF, 23'd0};
    end else begin
        r.result = to_fp32(sum);
    end
    return r;
endfunction

`endif

/* sim/tb_f8_dot_top.sv */
`timescale 1ns/1ps

module tb_f8_dot_top;

    localparam logic [2:0] fmt_fp8 = 3'd0;
    localparam logic [2:0] fmt_bf8 = 3'd1;

    logic              clk;
    logic              rst;
    logic              valid_in;
    logic [31:0]       req_id;
    logic [2:0]        fmt_f;
    logic [7:0]        vld_mask;
    logic [1:0][31:0]  a_row;
    logic [1:0][31:0]  b_col;
    logic              valid_out;
    logic [31:0]       req_id_out;
    logic [31:0]       result;
    logic              result_nan;
    logic              result_inf;
    logic              fmt_err;

    int          errors;
    int          err_mark;
    int          passes;
    int          fails;
    logic [31:0] tag_ctr;

    `include "tb_f8_model.svh"

    // Outstanding requests, oldest first
    exp_t exp_q[$];
    exp_t head;
    logic head_valid;

    f8_dot_top u_f8_dot_top (
        .clk(clk), .rst(rst), .valid_in(valid_in), .req_id(req_id), .fmt_f(fmt_f),
        .vld_mask(vld_mask), .a_row(a_row), .b_col(b_col), .valid_out(valid_out),
        .req_id_out(req_id_out), .result(result), .result_nan(result_nan),
        .result_inf(result_inf), .fmt_err(fmt_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void refresh_head();
        head_valid = (exp_q.size() > 0);
        if (head_valid) begin
            head = exp_q[0];
        end
    endfunction

    task automatic report_value(input string sig, input logic [31:0] expv,
                                input logic [31:0] actv);
        errors++;
        $display("FAIL at %0t: %s expected %h, got %h", $time, sig, expv, actv);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // ------------------------------------------------------------
    // Checks against the queue head
    // ------------------------------------------------------------
    a_result: assert property (@(posedge clk) disable iff (rst)
        valid_out && head_valid |-> result == head.result)
        else report_value("result", $sampled(head.result), $sampled(result));

    a_nan: assert property (@(posedge clk) disable iff (rst)
        valid_out && head_valid |-> result_nan == head.nan)
        else report_value("result_nan", 32'($sampled(head.nan)), 32'($sampled(result_nan)));

    a_inf: assert property (@(posedge clk) disable iff (rst)
        valid_out && head_valid |-> result_inf == head.inf)
        else report_value("result_inf", 32'($sampled(head.inf)), 32'($sampled(result_inf)));

    a_tag: assert property (@(posedge clk) disable iff (rst)
        valid_out && head_valid |-> req_id_out == head.tag)
        else report_value("req_id_out", $sampled(head.tag), $sampled(req_id_out));

    a_fmt_err: assert property (@(posedge clk) disable iff (rst)
        valid_out && head_valid |-> fmt_err == head.fmt_err)
        else report_value("fmt_err", 32'($sampled(head.fmt_err)), 32'($sampled(fmt_err)));

    // Fixed latency, no gaps and no extra strobes
    a_latency: assert property (@(posedge clk) disable iff (rst)
        valid_in |-> ##3 valid_out)
        else report_error("valid_out missing three cycles after valid_in");

    a_origin: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> $past(valid_in, 3))
        else report_error("valid_out without valid_in three cycles earlier");

    a_expected: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> head_valid)
        else report_error("valid_out with no request outstanding");

    // Retire the head once its result has been seen
    always @(posedge clk) begin
        if (valid_out === 1'b1 && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    task automatic issue(input logic [2:0] fmt, input logic [7:0] mask,
                         input logic [63:0] a, input logic [63:0] b);
        @(posedge clk);
        #2;
        valid_in = 1'b1;
        fmt_f    = fmt;
        vld_mask = mask;
        a_row    = a;
        b_col    = b;
        req_id   = tag_ctr;
        exp_q.push_back(model_dot(fmt, mask, a, b, tag_ctr));
        refresh_head();
        tag_ctr  = tag_ctr + 1;
    endtask

    task automatic idle();
        @(posedge clk);
        #2;
        valid_in = 1'b0;
    endtask

    // Bounded wait for every outstanding result
    task automatic wait_results(input string name);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("%s timed out with %0d results missing", name,
                                   exp_q.size()));
            exp_q.delete();
            refresh_head();
        end
    endtask

    task automatic finish_test(input string name);
        idle();
        wait_results(name);
        if (errors == err_mark) begin
            passes++;
            $display("%s: ok", name);
        end else begin
            fails++;
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        rst        = 1'b1;
        valid_in   = 1'b0;
        req_id     = '0;
        fmt_f      = fmt_fp8;
        vld_mask   = '0;
        a_row      = '0;
        b_col      = '0;
        rng_state  = 32'd98;
        tag_ctr    = 32'd1;
        errors     = 0;
        err_mark   = 0;
        passes     = 0;
        fails      = 0;
        head       = '0;
        head_valid = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // Full-mask random sums
        repeat (30) begin
            issue(fmt_fp8, 8'hFF, rand_vec(1'b0), rand_vec(1'b0));
            idle();
        end
        finish_test("fp8 random sums");

        repeat (30) begin
            issue(fmt_bf8, 8'hFF, rand_vec(1'b1), rand_vec(1'b1));
            idle();
        end
        finish_test("bf8 random sums");

        // Masked NaN and Inf, cancellation, empty mask
        issue(fmt_fp8, 8'h7F, {8'h7F, {7{8'h38}}}, {8{8'h38}});
        issue(fmt_bf8, 8'h7F, {8'h7C, {7{8'h3C}}}, {8{8'h3C}});
        issue(fmt_fp8, 8'hFF, {8{8'h38}}, {4{8'hB8, 8'h38}});
        issue(fmt_fp8, 8'hFF, {8{8'h38}}, {{5{8'h00}}, 8'hBC, 8'h00, 8'h3C});
        issue(fmt_fp8, 8'h00, rand_vec(1'b0), rand_vec(1'b0));
        repeat (10) begin
            issue(fmt_fp8, 8'(next_rand()), rand_vec(1'b0), rand_vec(1'b0));
        end
        finish_test("mask and cancellation");

        // NaN, Inf times zero, mixed Inf, signed Inf, fp8 top codes
        issue(fmt_fp8, 8'hFF, {{4{8'h38}}, 8'h7F, {3{8'h38}}}, {8{8'h38}});
        issue(fmt_bf8, 8'hFF, {{7{8'h3C}}, 8'h7C}, {{7{8'h3C}}, 8'h00});
        issue(fmt_bf8, 8'hFF, {{5{8'h3C}}, 8'hFC, 8'h3C, 8'h7C}, {8{8'h3C}});
        issue(fmt_bf8, 8'hFF, {{2{8'h3C}}, 8'hFC, {5{8'h3C}}}, {8{8'h3C}});
        issue(fmt_fp8, 8'hFF, {8'h38, 8'hFF, {6{8'h38}}}, {8{8'h38}});
        issue(fmt_fp8, 8'hFF, {{7{8'h38}}, 8'h7E}, {8{8'h38}});
        finish_test("exceptions");

        issue(3'd2, 8'hFF, rand_vec(1'b0), rand_vec(1'b0));
        issue(3'd5, 8'hFF, rand_vec(1'b1), rand_vec(1'b1));
        issue(3'd7, 8'h0F, rand_vec(1'b0), rand_vec(1'b0));
        finish_test("illegal format");

        // Consecutive cycles, alternating formats
        repeat (4) begin
            issue(fmt_fp8, 8'hFF, rand_vec(1'b0), rand_vec(1'b0));
            issue(fmt_bf8, 8'hFF, rand_vec(1'b1), rand_vec(1'b1));
        end
        finish_test("back-to-back");

        $display("Summary: %0d tests passed, %0d failed", passes, fails);
        if (fails == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
